/* src/ppu_pkg.sv */
// Shared widths, APB register offsets and pixel colour helpers for the PPU
package ppu_pkg;

	localparam int W_COORD       = 10;
	localparam int W_PIXDATA     = 15;
	localparam int W_LCD_PIXDATA = 16;
	localparam int W_PALETTE_IDX = 8;
	localparam int W_LOG_COORD   = 4;
	localparam int W_ADDR        = 32;
	localparam int W_DATA        = 32;

	// ----------------------------------------
	// APB register map

	localparam logic [7:0] REG_CSR        = 8'h00;
	localparam logic [7:0] REG_DISPSIZE   = 8'h04;
	localparam logic [7:0] REG_BEAM       = 8'h08;
	localparam logic [7:0] REG_DEFAULT_BG = 8'h0c;
	localparam logic [7:0] REG_BG0_CSR    = 8'h10;
	localparam logic [7:0] REG_BG0_SCROLL = 8'h14;
	localparam logic [7:0] REG_BG0_FBBASE = 8'h18;
	localparam logic [7:0] REG_LCD_CSR    = 8'h1c;

	// Writes with this address bit set land in palette RAM
	localparam int PRAM_WINDOW_BIT = 8;

	// Green gets a zero LSB to go from 5 to 6 bits
	function automatic logic [W_LCD_PIXDATA-1:0] rgb555_to_565(input logic [W_PIXDATA-1:0] c);
		return {c[14:5], 1'b0, c[4:0]};
	endfunction

endpackage

/* src/ppu_regs.sv */
// APB slave register block with palette RAM write window
`timescale 1ns/1ps

module ppu_regs (
	input  logic                             clk_ppu,
	input  logic                             rst_n_ppu,
	input  logic                             psel_i,
	input  logic                             penable_i,
	input  logic                             pwrite_i,
	input  logic [15:0]                      paddr_i,
	input  logic [ppu_pkg::W_DATA-1:0]       pwdata_i,
	output logic [ppu_pkg::W_DATA-1:0]       prdata_o,
	output logic                             pready_o,
	output logic                             pslverr_o,
	output logic                             run_o,
	output logic                             halt_o,
	output logic                             halt_vsync_o,
	output logic [ppu_pkg::W_COORD-1:0]      disp_w_o,
	output logic [ppu_pkg::W_COORD-1:0]      disp_h_o,
	output logic [ppu_pkg::W_PIXDATA-1:0]    default_bg_o,
	output logic                             bg_en_o,
	output logic                             bg_transparency_o,
	output logic [ppu_pkg::W_LOG_COORD-1:0]  bg_log_w_o,
	output logic [ppu_pkg::W_LOG_COORD-1:0]  bg_log_h_o,
	output logic [ppu_pkg::W_COORD-1:0]      bg_scroll_x_o,
	output logic [ppu_pkg::W_COORD-1:0]      bg_scroll_y_o,
	output logic [ppu_pkg::W_ADDR-1:0]       bg_fbbase_o,
	output logic                             lcd_cs_o,
	output logic                             lcd_dc_o,
	output logic                             pram_wen_o,
	output logic [ppu_pkg::W_PALETTE_IDX-1:0] pram_waddr_o,
	output logic [ppu_pkg::W_PIXDATA-1:0]    pram_wdata_o,
	input  logic                             running_i,
	input  logic [ppu_pkg::W_COORD-1:0]      beam_x_i,
	input  logic [ppu_pkg::W_COORD-1:0]      beam_y_i,
	input  logic                             tx_busy_i
);
	import ppu_pkg::*;

	logic wen;
	logic reg_hit;
	logic pram_hit;
	logic csr_wen;

	// Zero-wait slave, never errors
	assign pready_o  = 1'b1;
	assign pslverr_o = 1'b0;

	assign wen      = psel_i && penable_i && pwrite_i;
	assign reg_hit  = paddr_i[15:PRAM_WINDOW_BIT+1] == '0 && !paddr_i[PRAM_WINDOW_BIT];
	assign pram_hit = paddr_i[15:PRAM_WINDOW_BIT+1] == '0 && paddr_i[PRAM_WINDOW_BIT];
	assign csr_wen  = wen && reg_hit && paddr_i[7:0] == REG_CSR;

	// Run and halt are strobes, only live during the access phase
	assign run_o  = csr_wen && pwdata_i[0];
	assign halt_o = csr_wen && pwdata_i[1];

	assign pram_wen_o   = wen && pram_hit;
	assign pram_waddr_o = paddr_i[W_PALETTE_IDX-1:0];
	assign pram_wdata_o = pwdata_i[W_PIXDATA-1:0];

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			halt_vsync_o      <= 1'b0;
			disp_w_o          <= '0;
			disp_h_o          <= '0;
			default_bg_o      <= '0;
			bg_en_o           <= 1'b0;
			bg_transparency_o <= 1'b0;
			bg_log_w_o        <= '0;
			bg_log_h_o        <= '0;
			bg_scroll_x_o     <= '0;
			bg_scroll_y_o     <= '0;
			bg_fbbase_o       <= '0;
			lcd_cs_o          <= 1'b1;
			lcd_dc_o          <= 1'b0;
		end else if (wen && reg_hit) begin
			case (paddr_i[7:0])
			REG_CSR: halt_vsync_o <= pwdata_i[2];
			REG_DISPSIZE: begin
				disp_w_o <= pwdata_i[W_COORD-1:0];
				disp_h_o <= pwdata_i[16 +: W_COORD];
			end
			REG_DEFAULT_BG: default_bg_o <= pwdata_i[W_PIXDATA-1:0];
			REG_BG0_CSR: begin
				bg_en_o           <= pwdata_i[0];
				bg_transparency_o <= pwdata_i[1];
				bg_log_w_o        <= pwdata_i[4 +: W_LOG_COORD];
				bg_log_h_o        <= pwdata_i[8 +: W_LOG_COORD];
			end
			REG_BG0_SCROLL: begin
				bg_scroll_x_o <= pwdata_i[W_COORD-1:0];
				bg_scroll_y_o <= pwdata_i[16 +: W_COORD];
			end
			REG_BG0_FBBASE: bg_fbbase_o <= pwdata_i;
			REG_LCD_CSR: begin
				lcd_cs_o <= pwdata_i[0];
				lcd_dc_o <= pwdata_i[1];
			end
			default: ;
			endcase
		end
	end

	// ----------------------------------------
	// Read mux, returned in the access phase

	always_comb begin
		prdata_o = '0;
		if (reg_hit) begin
			case (paddr_i[7:0])
			REG_CSR: begin
				prdata_o[0] = running_i;
				prdata_o[2] = halt_vsync_o;
				prdata_o[3] = tx_busy_i;
			end
			REG_DISPSIZE: begin
				prdata_o[W_COORD-1:0]   = disp_w_o;
				prdata_o[16 +: W_COORD] = disp_h_o;
			end
			REG_BEAM: begin
				prdata_o[W_COORD-1:0]   = beam_x_i;
				prdata_o[16 +: W_COORD] = beam_y_i;
			end
			REG_DEFAULT_BG: prdata_o[W_PIXDATA-1:0] = default_bg_o;
			REG_BG0_CSR: begin
				prdata_o[0]               = bg_en_o;
				prdata_o[1]               = bg_transparency_o;
				prdata_o[4 +: W_LOG_COORD] = bg_log_w_o;
				prdata_o[8 +: W_LOG_COORD] = bg_log_h_o;
			end
			REG_BG0_SCROLL: begin
				prdata_o[W_COORD-1:0]   = bg_scroll_x_o;
				prdata_o[16 +: W_COORD] = bg_scroll_y_o;
			end
			REG_BG0_FBBASE: prdata_o = bg_fbbase_o;
			REG_LCD_CSR: begin
				prdata_o[0] = lcd_cs_o;
				prdata_o[1] = lcd_dc_o;
			end
			default: prdata_o = '0;
			endcase
		end
	end

endmodule

/* src/ppu_raster_counter.sv */
// Beam position counter with row and frame pulses and the run/halt state
`timescale 1ns/1ps

module ppu_raster_counter (
	input  logic                        clk_ppu,
	input  logic                        rst_n_ppu,
	input  logic                        run_i,
	input  logic                        halt_i,
	input  logic                        halt_vsync_i,
	input  logic [ppu_pkg::W_COORD-1:0] w_i,
	input  logic [ppu_pkg::W_COORD-1:0] h_i,
	input  logic                        advance_i,
	output logic [ppu_pkg::W_COORD-1:0] x_o,
	output logic [ppu_pkg::W_COORD-1:0] y_o,
	output logic                        start_row_o,
	output logic                        start_frame_o,
	output logic                        running_o
);
	import ppu_pkg::*;

	logic x_last;
	logic y_last;
	logic running_q;

	assign x_last = x_o == w_i - 1'b1;
	assign y_last = y_o == h_i - 1'b1;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x_o           <= '0;
			y_o           <= '0;
			start_row_o   <= 1'b0;
			start_frame_o <= 1'b0;
		end else begin
			start_row_o   <= advance_i && x_last;
			start_frame_o <= advance_i && x_last && y_last;
			if (advance_i) begin
				if (x_last) begin
					x_o <= '0;
					y_o <= y_last ? '0 : y_o + 1'b1;
				end else begin
					x_o <= x_o + 1'b1;
				end
			end
		end
	end

	// Halt at vsync drops running in the same cycle as the frame pulse
	assign running_o = running_q && !(halt_vsync_i && start_frame_o);

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			running_q <= 1'b0;
		end else begin
			running_q <= (running_o || run_i) && !halt_i;
		end
	end

endmodule

/* src/ppu_background.sv */
// Bitmap background layer, fetches one palette index per beam pixel
`timescale 1ns/1ps

module ppu_background (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  logic                              en_i,
	input  logic                              running_i,
	input  logic                              flush_i,
	input  logic [ppu_pkg::W_COORD-1:0]       beam_x_i,
	input  logic [ppu_pkg::W_COORD-1:0]       beam_y_i,
	input  logic [ppu_pkg::W_COORD-1:0]       scroll_x_i,
	input  logic [ppu_pkg::W_COORD-1:0]       scroll_y_i,
	input  logic [ppu_pkg::W_LOG_COORD-1:0]   log_w_i,
	input  logic [ppu_pkg::W_LOG_COORD-1:0]   log_h_i,
	input  logic [ppu_pkg::W_ADDR-1:0]        fbbase_i,
	input  logic                              transparency_i,
	output logic                              req_vld_o,
	output logic [ppu_pkg::W_ADDR-1:0]        req_addr_o,
	input  logic                              req_rdy_i,
	input  logic [ppu_pkg::W_DATA-1:0]        req_data_i,
	output logic                              pix_vld_o,
	input  logic                              pix_rdy_i,
	output logic [ppu_pkg::W_PALETTE_IDX-1:0] pix_idx_o,
	output logic                              pix_alpha_o
);
	import ppu_pkg::*;

	logic [W_COORD-1:0]       mask_x;
	logic [W_COORD-1:0]       mask_y;
	logic [W_COORD-1:0]       pf_x;
	logic [W_COORD-1:0]       pf_y;
	logic [W_ADDR-1:0]        fetch_addr;
	logic [W_PALETTE_IDX-1:0] fetched;
	logic                     launch;

	// Playfield coordinates wrap at the power-of-two size
	assign mask_x = ~({W_COORD{1'b1}} << log_w_i);
	assign mask_y = ~({W_COORD{1'b1}} << log_h_i);
	assign pf_x   = (beam_x_i + scroll_x_i) & mask_x;
	assign pf_y   = (beam_y_i + scroll_y_i) & mask_y;

	assign fetch_addr = fbbase_i + (W_ADDR'(pf_y) << log_w_i) + W_ADDR'(pf_x);

	// Byte lane picked by the low address bits
	assign fetched = req_data_i[{req_addr_o[1:0], 3'b000} +: W_PALETTE_IDX];

	// One fetch in flight, and only into an empty output slot.
	// A row start holds off the launch for that cycle
	assign launch = running_i && !req_vld_o && !pix_vld_o && !flush_i;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			req_vld_o <= 1'b0;
			pix_vld_o <= 1'b0;
		end else begin
			if (launch) begin
				// Disabled layer skips the bus and emits a transparent pixel
				req_vld_o <= en_i;
				pix_vld_o <= !en_i;
			end else if (req_vld_o && req_rdy_i) begin
				req_vld_o <= 1'b0;
				pix_vld_o <= 1'b1;
			end else if (pix_vld_o && pix_rdy_i) begin
				pix_vld_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_ppu) begin
		if (launch) begin
			req_addr_o  <= fetch_addr;
			pix_idx_o   <= '0;
			pix_alpha_o <= 1'b0;
		end else if (req_vld_o && req_rdy_i) begin
			pix_idx_o   <= fetched;
			pix_alpha_o <= en_i && !(transparency_i && fetched == '0);
		end
	end

endmodule

/* src/ppu_busmaster.sv */
// AHB-lite master issuing single byte reads for the background fetcher
`timescale 1ns/1ps

module ppu_busmaster (
	input  logic                       clk_ppu,
	input  logic                       rst_n_ppu,
	input  logic                       req_vld_i,
	input  logic [ppu_pkg::W_ADDR-1:0] req_addr_i,
	output logic                       req_rdy_o,
	output logic [ppu_pkg::W_DATA-1:0] req_data_o,
	output logic [ppu_pkg::W_ADDR-1:0] haddr_o,
	output logic [1:0]                 htrans_o,
	output logic [2:0]                 hsize_o,
	output logic                       hwrite_o,
	input  logic                       hready_i,
	input  logic [ppu_pkg::W_DATA-1:0] hrdata_i,
	input  logic                       hresp_i
);
	import ppu_pkg::*;

	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	logic data_phase;
	logic addr_phase;

	// Requester holds its address until req_rdy, so haddr needs no register
	assign addr_phase = !data_phase && req_vld_i;

	assign haddr_o  = req_addr_i;
	assign htrans_o = addr_phase ? HTRANS_NONSEQ : HTRANS_IDLE;
	assign hsize_o  = 3'b000;
	assign hwrite_o = 1'b0;

	// Error responses are passed on as ordinary data
	assign req_rdy_o  = data_phase && hready_i;
	assign req_data_o = hrdata_i;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			data_phase <= 1'b0;
		end else if (data_phase) begin
			data_phase <= !hready_i;
		end else begin
			data_phase <= addr_phase && hready_i;
		end
	end

endmodule

/* src/ppu_palette_mapper.sv */
// Palette RAM lookup, transparency fill and RGB565 output register
`timescale 1ns/1ps

module ppu_palette_mapper (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  logic                              pix_vld_i,
	output logic                              pix_rdy_o,
	input  logic [ppu_pkg::W_PALETTE_IDX-1:0] pix_idx_i,
	input  logic                              pix_alpha_i,
	input  logic [ppu_pkg::W_PIXDATA-1:0]     default_bg_i,
	input  logic                              pram_wen_i,
	input  logic [ppu_pkg::W_PALETTE_IDX-1:0] pram_waddr_i,
	input  logic [ppu_pkg::W_PIXDATA-1:0]     pram_wdata_i,
	output logic                              out_vld_o,
	input  logic                              out_rdy_i,
	output logic [ppu_pkg::W_LCD_PIXDATA-1:0] out_data_o
);
	import ppu_pkg::*;

	logic [W_PIXDATA-1:0] pram [0:(1 << W_PALETTE_IDX)-1];
	logic [W_PIXDATA-1:0] rd_colour;
	logic                 rd_vld;
	logic                 rd_alpha;
	logic                 pipe_en;

	// Whole pipe stalls when the output register cannot drain
	assign pipe_en   = !out_vld_o || out_rdy_i;
	assign pix_rdy_o = pipe_en;

	// ----------------------------------------
	// Palette RAM, registered read

	always_ff @(posedge clk_ppu) begin
		if (pram_wen_i) begin
			pram[pram_waddr_i] <= pram_wdata_i;
		end
		if (pipe_en) begin
			rd_colour <= pram[pix_idx_i];
			rd_alpha  <= pix_alpha_i;
		end
	end

	// ----------------------------------------
	// Output stage

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			rd_vld    <= 1'b0;
			out_vld_o <= 1'b0;
		end else if (pipe_en) begin
			rd_vld    <= pix_vld_i;
			out_vld_o <= rd_vld;
		end
	end

	// Transparent pixels show the default background colour
	always_ff @(posedge clk_ppu) begin
		if (pipe_en) begin
			out_data_o <= rgb555_to_565(rd_alpha ? rd_colour : default_bg_i);
		end
	end

endmodule

/* src/ppu_pxfifo.sv */
// Synchronous first-word-fall-through FIFO for RGB565 pixels
`timescale 1ns/1ps

module ppu_pxfifo #(
	parameter int PXFIFO_DEPTH = 8
) (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  logic                              push_i,
	input  logic [ppu_pkg::W_LCD_PIXDATA-1:0] wdata_i,
	output logic                              full_o,
	input  logic                              pop_i,
	output logic [ppu_pkg::W_LCD_PIXDATA-1:0] rdata_o,
	output logic                              empty_o
);
	import ppu_pkg::*;

	localparam int W_PTR = $clog2(PXFIFO_DEPTH);

	logic [W_LCD_PIXDATA-1:0] mem [0:PXFIFO_DEPTH-1];
	// Extra pointer bit tells full from empty
	logic [W_PTR:0]           wptr;
	logic [W_PTR:0]           rptr;

	assign empty_o = wptr == rptr;
	assign full_o  = wptr == {~rptr[W_PTR], rptr[W_PTR-1:0]};
	assign rdata_o = mem[rptr[W_PTR-1:0]];

	always_ff @(posedge clk_ppu) begin
		if (push_i && !full_o) begin
			mem[wptr[W_PTR-1:0]] <= wdata_i;
		end
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push_i && !full_o) begin
				wptr <= wptr + 1'b1;
			end
			if (pop_i && !empty_o) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

endmodule

/* src/ppu_dispctrl.sv */
// SPI display shifter, sends FIFO words MSB first on lcd_sck/lcd_mosi
`timescale 1ns/1ps

module ppu_dispctrl (
	input  logic                              clk_ppu,
	input  logic                              rst_n_ppu,
	input  logic                              fifo_empty_i,
	input  logic [ppu_pkg::W_LCD_PIXDATA-1:0] fifo_rdata_i,
	output logic                              fifo_pop_o,
	output logic                              tx_busy_o,
	output logic                              lcd_sck_o,
	output logic                              lcd_mosi_o
);
	import ppu_pkg::*;

	localparam int W_CNT = $clog2(W_LCD_PIXDATA);

	logic [W_LCD_PIXDATA-1:0] shreg;
	logic [W_CNT-1:0]         bit_cnt;
	logic                     last_fall;

	// Final falling edge of a word; the next word loads right behind it
	assign last_fall  = tx_busy_o && lcd_sck_o && bit_cnt == W_CNT'(W_LCD_PIXDATA - 1);
	assign fifo_pop_o = !fifo_empty_i && (!tx_busy_o || last_fall);
	assign lcd_mosi_o = shreg[W_LCD_PIXDATA-1];

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			tx_busy_o <= 1'b0;
			lcd_sck_o <= 1'b0;
			bit_cnt   <= '0;
			shreg     <= '0;
		end else if (fifo_pop_o) begin
			tx_busy_o <= 1'b1;
			lcd_sck_o <= 1'b0;
			bit_cnt   <= '0;
			shreg     <= fifo_rdata_i;
		end else if (tx_busy_o) begin
			lcd_sck_o <= !lcd_sck_o;
			// Data moves on with the falling edge
			if (lcd_sck_o) begin
				shreg   <= shreg << 1;
				bit_cnt <= bit_cnt + 1'b1;
				if (last_fall) begin
					tx_busy_o <= 1'b0;
				end
			end
		end
	end

endmodule

/* src/ppu_top.sv */
// PPU top level, joins registers, raster, background, palette, FIFO and SPI
`timescale 1ns/1ps

module ppu_top #(
	parameter int PXFIFO_DEPTH = 8
) (
	input  logic                       clk_ppu,
	input  logic                       rst_n_ppu,
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  logic [15:0]                paddr_i,
	input  logic [ppu_pkg::W_DATA-1:0] pwdata_i,
	output logic [ppu_pkg::W_DATA-1:0] prdata_o,
	output logic                       pready_o,
	output logic                       pslverr_o,
	output logic [ppu_pkg::W_ADDR-1:0] haddr_o,
	output logic [1:0]                 htrans_o,
	output logic [2:0]                 hsize_o,
	output logic                       hwrite_o,
	input  logic                       hready_i,
	input  logic [ppu_pkg::W_DATA-1:0] hrdata_i,
	input  logic                       hresp_i,
	output logic                       lcd_cs_o,
	output logic                       lcd_dc_o,
	output logic                       lcd_sck_o,
	output logic                       lcd_mosi_o
);
	import ppu_pkg::*;

	logic                     run, halt, halt_vsync, running, tx_busy;
	logic [W_COORD-1:0]       disp_w, disp_h, beam_x, beam_y;
	logic [W_PIXDATA-1:0]     default_bg;
	logic                     bg_en, bg_transparency;
	logic [W_LOG_COORD-1:0]   bg_log_w, bg_log_h;
	logic [W_COORD-1:0]       bg_scroll_x, bg_scroll_y;
	logic [W_ADDR-1:0]        bg_fbbase;
	logic                     pram_wen;
	logic [W_PALETTE_IDX-1:0] pram_waddr;
	logic [W_PIXDATA-1:0]     pram_wdata;
	logic                     start_row;

	logic                     req_vld, req_rdy;
	logic [W_ADDR-1:0]        req_addr;
	logic [W_DATA-1:0]        req_data;
	logic                     pix_vld, pix_rdy, pix_alpha;
	logic [W_PALETTE_IDX-1:0] pix_idx;

	logic                     pmap_vld;
	logic [W_LCD_PIXDATA-1:0] pmap_data, fifo_rdata;
	logic                     fifo_full, fifo_empty, fifo_pop;

	// ----------------------------------------
	// Control and beam

	ppu_regs i_regs (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
		.paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
		.pready_o (pready_o), .pslverr_o (pslverr_o),
		.run_o (run), .halt_o (halt), .halt_vsync_o (halt_vsync),
		.disp_w_o (disp_w), .disp_h_o (disp_h), .default_bg_o (default_bg),
		.bg_en_o (bg_en), .bg_transparency_o (bg_transparency),
		.bg_log_w_o (bg_log_w), .bg_log_h_o (bg_log_h),
		.bg_scroll_x_o (bg_scroll_x), .bg_scroll_y_o (bg_scroll_y),
		.bg_fbbase_o (bg_fbbase), .lcd_cs_o (lcd_cs_o), .lcd_dc_o (lcd_dc_o),
		.pram_wen_o (pram_wen), .pram_waddr_o (pram_waddr), .pram_wdata_o (pram_wdata),
		.running_i (running), .beam_x_i (beam_x), .beam_y_i (beam_y),
		.tx_busy_i (tx_busy)
	);

	ppu_raster_counter i_raster (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.run_i (run), .halt_i (halt), .halt_vsync_i (halt_vsync),
		.w_i (disp_w), .h_i (disp_h), .advance_i (pix_vld && pix_rdy),
		.x_o (beam_x), .y_o (beam_y), .start_row_o (start_row),
		.start_frame_o (), .running_o (running)
	);

	// ----------------------------------------
	// Pixel path

	ppu_background i_bg0 (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.en_i (bg_en), .running_i (running), .flush_i (start_row),
		.beam_x_i (beam_x), .beam_y_i (beam_y),
		.scroll_x_i (bg_scroll_x), .scroll_y_i (bg_scroll_y),
		.log_w_i (bg_log_w), .log_h_i (bg_log_h), .fbbase_i (bg_fbbase),
		.transparency_i (bg_transparency),
		.req_vld_o (req_vld), .req_addr_o (req_addr),
		.req_rdy_i (req_rdy), .req_data_i (req_data),
		.pix_vld_o (pix_vld), .pix_rdy_i (pix_rdy),
		.pix_idx_o (pix_idx), .pix_alpha_o (pix_alpha)
	);

	ppu_busmaster i_busmaster (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.req_vld_i (req_vld), .req_addr_i (req_addr),
		.req_rdy_o (req_rdy), .req_data_o (req_data),
		.haddr_o (haddr_o), .htrans_o (htrans_o), .hsize_o (hsize_o),
		.hwrite_o (hwrite_o), .hready_i (hready_i), .hrdata_i (hrdata_i),
		.hresp_i (hresp_i)
	);

	ppu_palette_mapper i_pmap (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.pix_vld_i (pix_vld), .pix_rdy_o (pix_rdy),
		.pix_idx_i (pix_idx), .pix_alpha_i (pix_alpha), .default_bg_i (default_bg),
		.pram_wen_i (pram_wen), .pram_waddr_i (pram_waddr), .pram_wdata_i (pram_wdata),
		.out_vld_o (pmap_vld), .out_rdy_i (!fifo_full), .out_data_o (pmap_data)
	);

	// ----------------------------------------
	// Display output

	ppu_pxfifo #(
		.PXFIFO_DEPTH (PXFIFO_DEPTH)
	) i_pxfifo (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.push_i (pmap_vld && !fifo_full), .wdata_i (pmap_data), .full_o (fifo_full),
		.pop_i (fifo_pop), .rdata_o (fifo_rdata), .empty_o (fifo_empty)
	);

	ppu_dispctrl i_dispctrl (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.fifo_empty_i (fifo_empty), .fifo_rdata_i (fifo_rdata), .fifo_pop_o (fifo_pop),
		.tx_busy_o (tx_busy), .lcd_sck_o (lcd_sck_o), .lcd_mosi_o (lcd_mosi_o)
	);

endmodule

/* tb/tb_ppu_ahb_mem.sv */
// AHB-lite read-only memory model with random wait states
`timescale 1ns/1ps

module tb_ppu_ahb_mem #(
	parameter int unsigned SEED = 56690
) (
	input  logic        clk_ppu,
	input  logic        rst_n_ppu,
	input  logic [31:0] haddr_i,
	input  logic [1:0]  htrans_i,
	output logic        hready_o,
	output logic [31:0] hrdata_o,
	output logic        hresp_o
);

	logic [31:0] addr_q;
	int          wait_cnt;

	// Byte at address A is A[7:0] ^ 0x5A, placed in lane A[1:0]
	function automatic logic [31:0] read_word(input logic [31:0] a);
		logic [7:0] b;
		b = a[7:0] ^ 8'h5a;
		return 32'(b) << (8 * a[1:0]);
	endfunction

	initial begin
		hready_o = 1'b1;
		hrdata_o = '0;
		hresp_o  = 1'b0;
		addr_q   = '0;
		wait_cnt = 0;
		// Wait states come from one seeded random stream
		void'($urandom(SEED));
		forever begin
			// Sample on the edge, drive 1 ns later
			@(posedge clk_ppu);
			if (!rst_n_ppu) begin
				#1;
				hready_o = 1'b1;
				hrdata_o = '0;
			end else if (hready_o && htrans_i == 2'b10) begin
				addr_q   = haddr_i;
				wait_cnt = $urandom % 4;
				#1;
				hready_o = wait_cnt == 0;
				hrdata_o = (wait_cnt == 0) ? read_word(addr_q) : '0;
			end else if (!hready_o) begin
				wait_cnt = wait_cnt - 1;
				#1;
				hready_o = wait_cnt == 0;
				hrdata_o = (wait_cnt == 0) ? read_word(addr_q) : '0;
			end else begin
				#1;
				hready_o = 1'b1;
				hrdata_o = '0;
			end
		end
	end

endmodule

/* tb/tb_ppu.sv */
// Testbench top for the PPU: clock, APB driver, SPI decoder, checks, timeout
`timescale 1ns/1ps

module tb_ppu;
	import ppu_pkg::*;

	localparam int MAX_CYCLES = 6000;
	localparam int N_WORDS    = 64;

	logic        clk_ppu;
	logic        rst_n_ppu;
	logic        psel, penable, pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata, prdata;
	logic        pready, pslverr;
	logic [31:0] haddr, hrdata;
	logic [1:0]  htrans;
	logic [2:0]  hsize;
	logic        hwrite, hready, hresp;
	logic        lcd_cs, lcd_dc, lcd_sck, lcd_mosi;

	int          err_cnt;
	int          check_cnt;
	int          cycles;
	int          word_cnt;
	int          bit_cnt;
	logic [15:0] shift;
	logic [15:0] exp_words[$];
	logic [31:0] rd;
	logic [31:0] prev_haddr;
	logic [1:0]  prev_htrans;
	logic        prev_hready;

	ppu_top #(.PXFIFO_DEPTH(8)) i_dut (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
		.paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
		.pready_o (pready), .pslverr_o (pslverr),
		.haddr_o (haddr), .htrans_o (htrans), .hsize_o (hsize), .hwrite_o (hwrite),
		.hready_i (hready), .hrdata_i (hrdata), .hresp_i (hresp),
		.lcd_cs_o (lcd_cs), .lcd_dc_o (lcd_dc), .lcd_sck_o (lcd_sck), .lcd_mosi_o (lcd_mosi)
	);

	tb_ppu_ahb_mem #(.SEED(56690)) i_mem (
		.clk_ppu (clk_ppu), .rst_n_ppu (rst_n_ppu),
		.haddr_i (haddr), .htrans_i (htrans),
		.hready_o (hready), .hrdata_o (hrdata), .hresp_o (hresp)
	);

	always #2 clk_ppu = ~clk_ppu;

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		check_cnt++;
		assert (exp === act) else begin
			err_cnt++;
			$display("Error: %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic apb_write(input logic [15:0] a, input logic [31:0] d);
		@(posedge clk_ppu);
		#1;
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = a;
		pwdata = d;
		@(posedge clk_ppu);
		#1;
		penable = 1'b1;
		@(posedge clk_ppu);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] a, output logic [31:0] d);
		@(posedge clk_ppu);
		#1;
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = a;
		@(posedge clk_ppu);
		#1;
		penable = 1'b1;
		@(posedge clk_ppu);
		d = prdata;
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_and_readback(input string name, input logic [15:0] a,
			input logic [31:0] d);
		logic [31:0] r;
		apb_write(a, d);
		apb_read(a, r);
		check_value(name, d, r);
	endtask

	// Poll REG_CSR until the given bit reads the given value
	task automatic wait_csr_bit(input int b, input logic v);
		logic [31:0] r;
		apb_read(16'(REG_CSR), r);
		while (r[b] !== v) begin
			apb_read(16'(REG_CSR), r);
		end
	endtask

	function automatic logic [14:0] palette_entry(input int i);
		return 15'((i * 32'h0123) & 32'h7fff);
	endfunction

	// RGB565 from RGB555, red and blue kept, green gains a zero LSB
	function automatic logic [15:0] to_rgb565(input logic [14:0] c);
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
		r = c[14:10];
		g = c[9:5];
		b = c[4:0];
		return {r, g, 1'b0, b};
	endfunction

	// Expected words of one 8x4 frame, scroll (3,1), 8x4 playfield
	task automatic queue_frame(input logic [31:0] fb, input logic trans, input logic [14:0] bg);
		logic [31:0] a;
		logic [7:0]  idx;
		logic [14:0] col;
		for (int y = 0; y < 4; y++) begin
			for (int x = 0; x < 8; x++) begin
				a   = fb + 32'((((y + 1) & 3) << 3) + ((x + 3) & 7));
				idx = a[7:0] ^ 8'h5a;
				col = (trans && idx == 8'h00) ? bg : palette_entry(idx);
				exp_words.push_back(to_rgb565(col));
			end
		end
	endtask

	// ----------------------------------------
	// SPI decoder

	always @(posedge lcd_sck) begin
		shift = {shift[14:0], lcd_mosi};
		bit_cnt++;
		if (bit_cnt == 16) begin
			bit_cnt = 0;
			word_cnt++;
			if (exp_words.size() == 0) begin
				err_cnt++;
				$display("Display sent a word when none was expected");
			end else begin
				check_value("lcd_word", 32'(exp_words.pop_front()), 32'(shift));
			end
		end
	end

	// ----------------------------------------
	// Bus and pin rules

	always @(posedge clk_ppu) begin
		if (!rst_n_ppu) begin
			assert (htrans == 2'b00) else begin
				err_cnt++;
				$display("Error: htrans expected %h got %h", 2'b00, htrans);
			end
		end else begin
			if (htrans == 2'b10) begin
				assert (hsize == 3'b000) else begin
					err_cnt++;
					$display("Error: hsize expected %h got %h", 3'b000, hsize);
				end
				assert (!hwrite) else begin
					err_cnt++;
					$display("Error: hwrite expected %h got %h", 1'b0, hwrite);
				end
			end
			if (!prev_hready) begin
				assert (haddr == prev_haddr) else begin
					err_cnt++;
					$display("Error: haddr expected %h got %h", prev_haddr, haddr);
				end
				assert (htrans == prev_htrans) else begin
					err_cnt++;
					$display("Error: htrans expected %h got %h", prev_htrans, htrans);
				end
			end
			if (psel && penable) begin
				assert (pready === 1'b1) else begin
					err_cnt++;
					$display("Error: pready expected %h got %h", 1'b1, pready);
				end
				assert (pslverr === 1'b0) else begin
					err_cnt++;
					$display("Error: pslverr expected %h got %h", 1'b0, pslverr);
				end
			end
			if (!i_dut.tx_busy) begin
				assert (!lcd_sck) else begin
					err_cnt++;
					$display("Error: lcd_sck expected %h got %h", 1'b0, lcd_sck);
				end
			end
		end
		prev_haddr  = haddr;
		prev_htrans = htrans;
		prev_hready = hready;
	end

	always @(posedge clk_ppu) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		clk_ppu     = 1'b0;
		rst_n_ppu   = 1'b0;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		err_cnt     = 0;
		check_cnt   = 0;
		cycles      = 0;
		word_cnt    = 0;
		bit_cnt     = 0;
		shift       = '0;
		prev_haddr  = '0;
		prev_htrans = '0;
		prev_hready = 1'b1;
		repeat (2) @(posedge clk_ppu);
		#1;
		rst_n_ppu = 1'b1;

		check_value("lcd_cs", 1, lcd_cs);

		// Register readback
		write_and_readback("REG_CSR", 16'(REG_CSR), 32'h4);
		apb_write(16'(REG_CSR), 32'h0);
		write_and_readback("REG_DISPSIZE", 16'(REG_DISPSIZE), 32'h0004_0008);
		write_and_readback("REG_DEFAULT_BG", 16'(REG_DEFAULT_BG), 32'h2a55);
		write_and_readback("REG_BG0_CSR", 16'(REG_BG0_CSR), 32'h231);
		write_and_readback("REG_BG0_SCROLL", 16'(REG_BG0_SCROLL), 32'h0001_0003);
		write_and_readback("REG_BG0_FBBASE", 16'(REG_BG0_FBBASE), 32'h40);
		write_and_readback("REG_LCD_CSR", 16'(REG_LCD_CSR), 32'h2);
		check_value("lcd_cs", 0, lcd_cs);
		check_value("lcd_dc", 1, lcd_dc);
		apb_read(16'(REG_BEAM), rd);
		check_value("REG_BEAM", 0, rd);

		for (int i = 0; i < 256; i++) begin
			apb_write(16'h100 | 16'(i), 32'(palette_entry(i)));
		end

		// Frame 0x5A lies inside 0x40..0x5F, so index 0 appears in both frames
		queue_frame(32'h40, 1'b0, 15'h2a55);
		queue_frame(32'h40, 1'b1, 15'h2a55);

		// First frame, transparency off
		apb_write(16'(REG_CSR), 32'h1);
		apb_write(16'(REG_CSR), 32'h4);
		wait_csr_bit(0, 1'b0);

		// Second frame, transparency on
		apb_write(16'(REG_BG0_CSR), 32'h233);
		apb_write(16'(REG_CSR), 32'h1);
		apb_write(16'(REG_CSR), 32'h4);
		wait_csr_bit(0, 1'b0);

		while (word_cnt < N_WORDS) begin
			@(posedge clk_ppu);
		end
		wait_csr_bit(3, 1'b0);
		repeat (100) @(posedge clk_ppu);
		check_value("word_cnt", N_WORDS, word_cnt);
		check_value("words_left", 0, exp_words.size());
		apb_read(16'(REG_CSR), rd);
		check_value("running", 0, 32'(rd[0]));
		check_value("tx_busy", 0, 32'(rd[3]));

		$display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
src/ppu_pkg.sv
src/ppu_regs.sv
src/ppu_raster_counter.sv
src/ppu_background.sv
src/ppu_busmaster.sv
src/ppu_palette_mapper.sv
src/ppu_pxfifo.sv
src/ppu_dispctrl.sv
src/ppu_top.sv
tb/tb_ppu_ahb_mem.sv
tb/tb_ppu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the PPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ppu -o tb_ppu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_ppu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1
